//--- l2_consts.svh
`ifndef L2_CONSTS_SVH
`define L2_CONSTS_SVH

// byte address width.
`define L2_ADDR_BITS 32
// 32-byte lines.
`define L2_OFFSET_BITS 5
// eight sets.
`define L2_INDEX_BITS 3
`define L2_TAG_BITS 24
`define L2_LINE_BITS 256
`define L2_WAYS 4

`endif

//--- l2_types_pkg.sv
`default_nettype none

`include "l2_consts.svh"

package l2_types_pkg;

	typedef logic [`L2_ADDR_BITS-1:0] l2_addr_t;
	typedef logic [`L2_TAG_BITS-1:0] l2_tag_t;
	typedef logic [`L2_INDEX_BITS-1:0] l2_index_t;
	typedef logic [`L2_LINE_BITS-1:0] l2_line_t;

	// bit 2 picks pair 1-2 or 3-4, bit 1 way 1 or 2, bit 0 way 3 or 4.
	typedef logic [2:0] l2_plru_t;

endpackage : l2_types_pkg

`default_nettype wire

//--- l2_ctrl_pkg.sv
`default_nettype none

`include "l2_consts.svh"

package l2_ctrl_pkg;

	typedef enum logic [1:0] {
		idle,
		read,
		write_mem,
		resp
	} l2_state_t;

	typedef enum logic [$clog2(`L2_WAYS)-1:0] {
		dsel_way1 = 2'd0,
		dsel_way2 = 2'd1,
		dsel_way3 = 2'd2,
		dsel_way4 = 2'd3
	} l2_datamux_t;

	// requester address or one of the stored tags.
	typedef enum logic [$clog2(`L2_WAYS+1)-1:0] {
		asel_mem = 3'd0,
		asel_tag1 = 3'd1,
		asel_tag2 = 3'd2,
		asel_tag3 = 3'd3,
		asel_tag4 = 3'd4
	} l2_addrmux_t;

endpackage : l2_ctrl_pkg

`default_nettype wire

//--- l2_tag_lookup.sv
`default_nettype none

`include "l2_consts.svh"

module l2_tag_lookup (
	input logic clk,
	input logic rst,
	input l2_types_pkg::l2_addr_t mem_address,
	input logic ld_tag1, ld_tag2, ld_tag3, ld_tag4,
	input logic ld_valid1, ld_valid2, ld_valid3, ld_valid4,
	input logic ld_dirty1, ld_dirty2, ld_dirty3, ld_dirty4,
	input logic dirty1_in, dirty2_in, dirty3_in, dirty4_in,
	input logic ld_lru,
	output logic way_match1, way_match2, way_match3, way_match4,
	output logic hit,
	output logic dirty1_out, dirty2_out, dirty3_out, dirty4_out,
	output l2_types_pkg::l2_plru_t lru_out,
	output l2_types_pkg::l2_tag_t tag1, tag2, tag3, tag4
);

	localparam int unsigned sets = 1 << `L2_INDEX_BITS;

	l2_types_pkg::l2_tag_t tag_arr [`L2_WAYS][sets];
	logic valid_arr [`L2_WAYS][sets];
	logic dirty_arr [`L2_WAYS][sets];
	l2_types_pkg::l2_plru_t lru_arr [sets];

	l2_types_pkg::l2_index_t idx;
	l2_types_pkg::l2_tag_t addr_tag;
	l2_types_pkg::l2_plru_t lru_next;
	logic [`L2_WAYS-1:0] match, ld_tag, ld_valid, ld_dirty, dirty_in;

	assign idx = mem_address[`L2_OFFSET_BITS +: `L2_INDEX_BITS];
	assign addr_tag = mem_address[`L2_ADDR_BITS-1 -: `L2_TAG_BITS];

	assign ld_tag = {ld_tag4, ld_tag3, ld_tag2, ld_tag1};
	assign ld_valid = {ld_valid4, ld_valid3, ld_valid2, ld_valid1};
	assign ld_dirty = {ld_dirty4, ld_dirty3, ld_dirty2, ld_dirty1};
	assign dirty_in = {dirty4_in, dirty3_in, dirty2_in, dirty1_in};

	always_comb begin
		for (int w = 0; w < `L2_WAYS; w++) begin
			match[w] = valid_arr[w][idx] && (tag_arr[w][idx] == addr_tag);
		end
	end

	assign {way_match4, way_match3, way_match2, way_match1} = match;
	assign hit = |match;

	assign dirty1_out = dirty_arr[0][idx];
	assign dirty2_out = dirty_arr[1][idx];
	assign dirty3_out = dirty_arr[2][idx];
	assign dirty4_out = dirty_arr[3][idx];
	assign tag1 = tag_arr[0][idx];
	assign tag2 = tag_arr[1][idx];
	assign tag3 = tag_arr[2][idx];
	assign tag4 = tag_arr[3][idx];
	assign lru_out = lru_arr[idx];

	// point the tree away from the way that hit.
	always_comb begin
		lru_next = lru_arr[idx];
		if (match[0]) begin
			lru_next[2:1] = 2'b11;
		end else if (match[1]) begin
			lru_next[2:1] = 2'b10;
		end else if (match[2]) begin
			lru_next[2] = 1'b0;
			lru_next[0] = 1'b1;
		end else if (match[3]) begin
			lru_next[2] = 1'b0;
			lru_next[0] = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		for (int w = 0; w < `L2_WAYS; w++) begin
			if (ld_tag[w])
				tag_arr[w][idx] <= addr_tag;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < sets; s++) begin
				lru_arr[s] <= '0;
				for (int w = 0; w < `L2_WAYS; w++) begin
					valid_arr[w][s] <= 1'b0;
					dirty_arr[w][s] <= 1'b0;
				end
			end
		end else begin
			for (int w = 0; w < `L2_WAYS; w++) begin
				if (ld_valid[w])
					valid_arr[w][idx] <= 1'b1;
				if (ld_dirty[w])
					dirty_arr[w][idx] <= dirty_in[w];
			end
			if (ld_lru)
				lru_arr[idx] <= lru_next;
		end
	end

endmodule : l2_tag_lookup

`default_nettype wire

//--- l2_cache_control.sv
`default_nettype none

module l2_cache_control (
	input logic clk,
	input logic rst,
	input logic mem_read,
	input logic mem_write,
	input logic pmem_resp,
	input logic hit,
	input logic way_match1, way_match2, way_match3, way_match4,
	input logic dirty1_out, dirty2_out, dirty3_out, dirty4_out,
	input l2_types_pkg::l2_plru_t lru_out,
	output logic ld_tag1, ld_tag2, ld_tag3, ld_tag4,
	output logic ld_valid1, ld_valid2, ld_valid3, ld_valid4,
	output logic ld_dirty1, ld_dirty2, ld_dirty3, ld_dirty4,
	output logic dirty1_in, dirty2_in, dirty3_in, dirty4_in,
	output logic ld_lru,
	output logic ld_way1, ld_way2, ld_way3, ld_way4,
	output logic way1mux_sel, way2mux_sel, way3mux_sel, way4mux_sel,
	output l2_ctrl_pkg::l2_datamux_t datamux_sel,
	output l2_ctrl_pkg::l2_addrmux_t addrmux_sel,
	output logic pmem_read,
	output logic pmem_write,
	output logic mem_resp
);

	l2_ctrl_pkg::l2_state_t state, next_state;
	l2_ctrl_pkg::l2_datamux_t hit_dsel, vict_dsel;
	l2_ctrl_pkg::l2_addrmux_t vict_asel;
	logic [3:0] match, dirty, victim;
	logic [3:0] ld_tag, ld_valid, ld_dirty, dirty_in, ld_way, wmux;
	logic victim_dirty;

	assign match = {way_match4, way_match3, way_match2, way_match1};
	assign dirty = {dirty4_out, dirty3_out, dirty2_out, dirty1_out};
	assign victim_dirty = |(victim & dirty);

	// victim way from the tree bits.
	always_comb begin
		if (lru_out[2:1] == 2'b00) begin
			victim = 4'b0001;
			vict_dsel = l2_ctrl_pkg::dsel_way1;
			vict_asel = l2_ctrl_pkg::asel_tag1;
		end else if (lru_out[2:1] == 2'b01) begin
			victim = 4'b0010;
			vict_dsel = l2_ctrl_pkg::dsel_way2;
			vict_asel = l2_ctrl_pkg::asel_tag2;
		end else if (lru_out[0] == 1'b0) begin
			victim = 4'b0100;
			vict_dsel = l2_ctrl_pkg::dsel_way3;
			vict_asel = l2_ctrl_pkg::asel_tag3;
		end else begin
			victim = 4'b1000;
			vict_dsel = l2_ctrl_pkg::dsel_way4;
			vict_asel = l2_ctrl_pkg::asel_tag4;
		end
	end

	always_comb begin
		if (way_match1)
			hit_dsel = l2_ctrl_pkg::dsel_way1;
		else if (way_match2)
			hit_dsel = l2_ctrl_pkg::dsel_way2;
		else if (way_match3)
			hit_dsel = l2_ctrl_pkg::dsel_way3;
		else
			hit_dsel = l2_ctrl_pkg::dsel_way4;
	end

	always_comb begin
		ld_tag = '0;
		ld_valid = '0;
		ld_dirty = '0;
		dirty_in = '0;
		ld_way = '0;
		wmux = '0;
		ld_lru = 1'b0;
		datamux_sel = hit_dsel;
		addrmux_sel = l2_ctrl_pkg::asel_mem;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		mem_resp = 1'b0;
		case (state)
			l2_ctrl_pkg::idle: begin
				// write hit lands in the matching way and marks it dirty.
				if (hit && mem_write) begin
					ld_lru = 1'b1;
					ld_way = match;
					ld_dirty = match;
					dirty_in = match;
				end
			end
			l2_ctrl_pkg::read: begin
				if (!hit) begin
					if (!victim_dirty) begin
						pmem_read = 1'b1;
						wmux = victim;
						if (pmem_resp) begin
							ld_valid = victim;
							ld_tag = victim;
							ld_way = victim;
						end
					end else begin
						datamux_sel = vict_dsel;
						addrmux_sel = vict_asel;
					end
				end
			end
			l2_ctrl_pkg::write_mem: begin
				pmem_write = 1'b1;
				datamux_sel = vict_dsel;
				addrmux_sel = vict_asel;
				// the victim is clean once written back.
				if (pmem_resp)
					ld_dirty = victim;
			end
			l2_ctrl_pkg::resp: begin
				mem_resp = 1'b1;
				ld_lru = 1'b1;
			end
			default: ;
		endcase
	end

	always_comb begin
		next_state = state;
		case (state)
			l2_ctrl_pkg::idle: begin
				if (mem_read || mem_write)
					next_state = hit ? l2_ctrl_pkg::resp : l2_ctrl_pkg::read;
			end
			l2_ctrl_pkg::read: begin
				if (victim_dirty)
					next_state = l2_ctrl_pkg::write_mem;
				else if (pmem_resp)
					next_state = mem_read ? l2_ctrl_pkg::resp : l2_ctrl_pkg::idle;
			end
			l2_ctrl_pkg::write_mem: begin
				if (pmem_resp)
					next_state = l2_ctrl_pkg::read;
			end
			default: next_state = l2_ctrl_pkg::idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= l2_ctrl_pkg::idle;
		else
			state <= next_state;
	end

	assign {ld_tag4, ld_tag3, ld_tag2, ld_tag1} = ld_tag;
	assign {ld_valid4, ld_valid3, ld_valid2, ld_valid1} = ld_valid;
	assign {ld_dirty4, ld_dirty3, ld_dirty2, ld_dirty1} = ld_dirty;
	assign {dirty4_in, dirty3_in, dirty2_in, dirty1_in} = dirty_in;
	assign {ld_way4, ld_way3, ld_way2, ld_way1} = ld_way;
	assign {way4mux_sel, way3mux_sel, way2mux_sel, way1mux_sel} = wmux;

endmodule : l2_cache_control

`default_nettype wire

//--- l2_data_path.sv
`default_nettype none

`include "l2_consts.svh"

module l2_data_path (
	input logic clk,
	input l2_types_pkg::l2_addr_t mem_address,
	input l2_types_pkg::l2_line_t mem_wdata,
	input l2_types_pkg::l2_line_t pmem_rdata,
	input logic ld_way1, ld_way2, ld_way3, ld_way4,
	input logic way1mux_sel, way2mux_sel, way3mux_sel, way4mux_sel,
	input l2_ctrl_pkg::l2_datamux_t datamux_sel,
	input l2_ctrl_pkg::l2_addrmux_t addrmux_sel,
	input l2_types_pkg::l2_tag_t tag1, tag2, tag3, tag4,
	output l2_types_pkg::l2_line_t mem_rdata,
	output l2_types_pkg::l2_line_t pmem_wdata,
	output l2_types_pkg::l2_addr_t pmem_address
);

	localparam int unsigned sets = 1 << `L2_INDEX_BITS;

	l2_types_pkg::l2_line_t data_arr [`L2_WAYS][sets];
	l2_types_pkg::l2_index_t idx;
	l2_types_pkg::l2_line_t line_out;
	logic [`L2_WAYS-1:0] ld_way, wmux;

	assign idx = mem_address[`L2_OFFSET_BITS +: `L2_INDEX_BITS];
	assign ld_way = {ld_way4, ld_way3, ld_way2, ld_way1};
	assign wmux = {way4mux_sel, way3mux_sel, way2mux_sel, way1mux_sel};

	// the way select picks the memory fill over requester data.
	always_ff @(posedge clk) begin
		for (int w = 0; w < `L2_WAYS; w++) begin
			if (ld_way[w])
				data_arr[w][idx] <= wmux[w] ? pmem_rdata : mem_wdata;
		end
	end

	always_comb begin
		case (datamux_sel)
			l2_ctrl_pkg::dsel_way2: line_out = data_arr[1][idx];
			l2_ctrl_pkg::dsel_way3: line_out = data_arr[2][idx];
			l2_ctrl_pkg::dsel_way4: line_out = data_arr[3][idx];
			default: line_out = data_arr[0][idx];
		endcase
	end

	assign mem_rdata = line_out;
	assign pmem_wdata = line_out;

	// line aligned.
	always_comb begin
		case (addrmux_sel)
			l2_ctrl_pkg::asel_tag1:
				pmem_address = {tag1, idx, {`L2_OFFSET_BITS{1'b0}}};
			l2_ctrl_pkg::asel_tag2:
				pmem_address = {tag2, idx, {`L2_OFFSET_BITS{1'b0}}};
			l2_ctrl_pkg::asel_tag3:
				pmem_address = {tag3, idx, {`L2_OFFSET_BITS{1'b0}}};
			l2_ctrl_pkg::asel_tag4:
				pmem_address = {tag4, idx, {`L2_OFFSET_BITS{1'b0}}};
			default:
				pmem_address = {mem_address[`L2_ADDR_BITS-1:`L2_OFFSET_BITS],
					{`L2_OFFSET_BITS{1'b0}}};
		endcase
	end

endmodule : l2_data_path

`default_nettype wire

//--- l2_cache.sv
`default_nettype none

module l2_cache (
	input logic clk,
	input logic rst,
	input l2_types_pkg::l2_addr_t mem_address,
	input logic mem_read,
	input logic mem_write,
	input l2_types_pkg::l2_line_t mem_wdata,
	output l2_types_pkg::l2_line_t mem_rdata,
	output logic mem_resp,
	output l2_types_pkg::l2_addr_t pmem_address,
	output logic pmem_read,
	output logic pmem_write,
	output l2_types_pkg::l2_line_t pmem_wdata,
	input l2_types_pkg::l2_line_t pmem_rdata,
	input logic pmem_resp
);

	// lookup to controller.
	logic way_match1, way_match2, way_match3, way_match4;
	logic hit;
	logic dirty1_out, dirty2_out, dirty3_out, dirty4_out;
	l2_types_pkg::l2_plru_t lru_out;
	l2_types_pkg::l2_tag_t tag1, tag2, tag3, tag4;

	// controller to arrays.
	logic ld_tag1, ld_tag2, ld_tag3, ld_tag4;
	logic ld_valid1, ld_valid2, ld_valid3, ld_valid4;
	logic ld_dirty1, ld_dirty2, ld_dirty3, ld_dirty4;
	logic dirty1_in, dirty2_in, dirty3_in, dirty4_in;
	logic ld_lru;
	logic ld_way1, ld_way2, ld_way3, ld_way4;
	logic way1mux_sel, way2mux_sel, way3mux_sel, way4mux_sel;
	l2_ctrl_pkg::l2_datamux_t datamux_sel;
	l2_ctrl_pkg::l2_addrmux_t addrmux_sel;

	l2_tag_lookup l2_tag_lookup_i (.*);

	l2_cache_control l2_cache_control_i (.*);

	l2_data_path l2_data_path_i (.*);

endmodule : l2_cache

`default_nettype wire

//--- l2_cache_properties.sv
`default_nettype none

module l2_cache_properties (
	input logic clk,
	input logic rst,
	input logic mem_resp,
	input logic pmem_read,
	input logic pmem_write,
	input logic pmem_resp
);

	// failed assertions so far.
	int unsigned failures = 0;

	pmem_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(pmem_read && pmem_write))
		else begin
			failures++;
			$error("pmem_read and pmem_write are high together");
		end

	resp_single: assert property (@(posedge clk) disable iff (rst)
		mem_resp |=> !mem_resp)
		else begin
			failures++;
			$error("mem_resp stayed high for two cycles");
		end

	read_held: assert property (@(posedge clk) disable iff (rst)
		(pmem_read && !pmem_resp) |=> pmem_read)
		else begin
			failures++;
			$error("pmem_read dropped before pmem_resp");
		end

	write_held: assert property (@(posedge clk) disable iff (rst)
		(pmem_write && !pmem_resp) |=> pmem_write)
		else begin
			failures++;
			$error("pmem_write dropped before pmem_resp");
		end

	resp_after_reset: assert property (@(posedge clk) rst |=> !mem_resp)
		else begin
			failures++;
			$error("mem_resp high in the cycle after reset");
		end

endmodule : l2_cache_properties

bind l2_cache l2_cache_properties l2_cache_properties_i (.*);

`default_nettype wire

//--- l2_cache_tb.sv
`default_nettype none

`include "l2_consts.svh"

module l2_cache_tb;

	localparam int period = 40;
	localparam int timeout_cycles = 200;
	localparam int sets = 1 << `L2_INDEX_BITS;

	logic clk;
	logic rst;
	l2_types_pkg::l2_addr_t mem_address;
	logic mem_read;
	logic mem_write;
	l2_types_pkg::l2_line_t mem_wdata;
	l2_types_pkg::l2_line_t mem_rdata;
	logic mem_resp;
	l2_types_pkg::l2_addr_t pmem_address;
	logic pmem_read;
	logic pmem_write;
	l2_types_pkg::l2_line_t pmem_wdata;
	l2_types_pkg::l2_line_t pmem_rdata;
	logic pmem_resp;

	int checks = 0;
	int errors = 0;

	// physical memory contents and its access log.
	l2_types_pkg::l2_line_t mem_lines [l2_types_pkg::l2_addr_t];
	l2_types_pkg::l2_addr_t log_addr [$];
	logic log_wr [$];
	l2_types_pkg::l2_line_t log_data [$];

	// reference model of the cache state.
	l2_types_pkg::l2_tag_t m_tag [sets][`L2_WAYS];
	logic m_valid [sets][`L2_WAYS];
	logic m_dirty [sets][`L2_WAYS];
	l2_types_pkg::l2_line_t m_data [sets][`L2_WAYS];
	l2_types_pkg::l2_plru_t m_lru [sets];

	l2_cache l2_cache_i (.*);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	function automatic l2_types_pkg::l2_line_t random_line();
		l2_types_pkg::l2_line_t l;
		for (int i = 0; i < `L2_LINE_BITS / 32; i++)
			l[i*32 +: 32] = $urandom;
		return l;
	endfunction

	// first touch of a line gives it random contents.
	function automatic l2_types_pkg::l2_line_t line_at(l2_types_pkg::l2_addr_t a);
		if (!mem_lines.exists(a))
			mem_lines[a] = random_line();
		return mem_lines[a];
	endfunction

	function automatic l2_types_pkg::l2_addr_t addr_of(l2_types_pkg::l2_tag_t t,
			l2_types_pkg::l2_index_t i);
		return {t, i, {`L2_OFFSET_BITS{1'b0}}};
	endfunction

	// zero bits lead to the lower way.
	function automatic int victim_of(l2_types_pkg::l2_plru_t p);
		if (!p[2])
			return p[1] ? 1 : 0;
		return p[0] ? 3 : 2;
	endfunction

	function automatic l2_types_pkg::l2_plru_t touched(l2_types_pkg::l2_plru_t p, int w);
		case (w)
			0: p[2:1] = 2'b11;
			1: p[2:1] = 2'b10;
			2: {p[2], p[0]} = 2'b01;
			default: {p[2], p[0]} = 2'b00;
		endcase
		return p;
	endfunction

	task automatic check_word(input string name, input string what,
			input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[ERROR] %s %s expected %0h actual %0h", name, what, exp, act);
		end
	endtask

	task automatic check_line(input string name, input string what,
			input l2_types_pkg::l2_line_t exp, input l2_types_pkg::l2_line_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[ERROR] %s %s expected %0h actual %0h", name, what, exp, act);
		end
	endtask

	// behavioural memory that answers three cycles after a strobe.
	initial begin : pmem_model
		l2_types_pkg::l2_addr_t req_addr;
		logic req_wr;
		l2_types_pkg::l2_line_t req_data;
		pmem_resp = 1'b0;
		pmem_rdata = '0;
		forever begin
			@(negedge clk);
			if (!rst && (pmem_read || pmem_write)) begin
				req_addr = pmem_address;
				req_wr = pmem_write;
				req_data = req_wr ? pmem_wdata : line_at(pmem_address);
				log_addr.push_back(req_addr);
				log_wr.push_back(req_wr);
				log_data.push_back(req_data);
				repeat (3) @(posedge clk);
				#2;
				if (req_wr)
					mem_lines[req_addr] = req_data;
				pmem_rdata = req_data;
				pmem_resp = 1'b1;
				@(posedge clk);
				#2;
				pmem_resp = 1'b0;
			end
		end
	end

	// issues one request and checks it against the model.
	task automatic access(input string name, input l2_types_pkg::l2_addr_t addr,
			input logic is_write, input l2_types_pkg::l2_line_t wdata,
			output int latency, output l2_types_pkg::l2_line_t rdata);
		l2_types_pkg::l2_index_t idx;
		l2_types_pkg::l2_tag_t tag;
		l2_types_pkg::l2_addr_t line_addr;
		l2_types_pkg::l2_addr_t exp_addr [$];
		logic exp_wr [$];
		l2_types_pkg::l2_line_t exp_data [$];
		int way;
		int start;
		int cycles;
		logic got;
		idx = addr[`L2_OFFSET_BITS +: `L2_INDEX_BITS];
		tag = addr[`L2_ADDR_BITS-1 -: `L2_TAG_BITS];
		line_addr = addr_of(tag, idx);
		way = -1;
		for (int w = 0; w < `L2_WAYS; w++) begin
			if (m_valid[idx][w] && m_tag[idx][w] == tag)
				way = w;
		end
		if (way < 0) begin
			way = victim_of(m_lru[idx]);
			if (m_valid[idx][way] && m_dirty[idx][way]) begin
				exp_addr.push_back(addr_of(m_tag[idx][way], idx));
				exp_wr.push_back(1'b1);
				exp_data.push_back(m_data[idx][way]);
			end
			exp_addr.push_back(line_addr);
			exp_wr.push_back(1'b0);
			exp_data.push_back(line_at(line_addr));
			m_tag[idx][way] = tag;
			m_valid[idx][way] = 1'b1;
			m_dirty[idx][way] = 1'b0;
			m_data[idx][way] = line_at(line_addr);
		end
		if (is_write) begin
			m_data[idx][way] = wdata;
			m_dirty[idx][way] = 1'b1;
		end
		m_lru[idx] = touched(m_lru[idx], way);

		start = log_addr.size();
		mem_address = addr;
		mem_read = !is_write;
		mem_write = is_write;
		mem_wdata = wdata;
		rdata = '0;
		got = 1'b0;
		cycles = 0;
		while (!got && cycles < timeout_cycles) begin
			@(negedge clk);
			if (mem_resp) begin
				got = 1'b1;
				rdata = mem_rdata;
			end else begin
				cycles++;
			end
		end
		@(posedge clk);
		#2;
		mem_read = 1'b0;
		mem_write = 1'b0;
		latency = cycles;
		if (!got) begin
			errors++;
			$display("%s: no mem_resp within %0d cycles", name, timeout_cycles);
			$display("checks %0d, errors %0d", checks, errors);
			$display("Errors found");
			$finish;
		end else begin
			check_word(name, "memory accesses", exp_addr.size(), log_addr.size() - start);
			if (log_addr.size() - start == exp_addr.size()) begin
				for (int i = 0; i < exp_addr.size(); i++) begin
					check_word(name, "memory address", exp_addr[i], log_addr[start+i]);
					check_word(name, "memory write", 32'(exp_wr[i]), 32'(log_wr[start+i]));
					if (exp_wr[i])
						check_line(name, "write-back data", exp_data[i], log_data[start+i]);
				end
			end
			if (!is_write)
				check_line(name, "read data", m_data[idx][way], rdata);
		end
	endtask

	task automatic reset_outputs_low();
		@(negedge clk);
		check_word("reset", "mem_resp", 32'd0, 32'(mem_resp));
		check_word("reset", "pmem_read", 32'd0, 32'(pmem_read));
		check_word("reset", "pmem_write", 32'd0, 32'(pmem_write));
		@(posedge clk);
		#2;
	endtask

	task automatic read_miss_then_hit();
		l2_types_pkg::l2_line_t first;
		l2_types_pkg::l2_line_t r;
		int lat;
		// unaligned offset in set 1.
		access("read_miss", 32'h00a1_b22c, 1'b0, '0, lat, first);
		access("read_hit", 32'h00a1_b22c, 1'b0, '0, lat, r);
		check_word("read_hit", "latency", 32'd1, lat);
		check_line("read_hit", "data", first, r);
	endtask

	task automatic write_hit_then_read();
		l2_types_pkg::l2_line_t d;
		l2_types_pkg::l2_line_t r;
		int lat;
		d = random_line();
		access("write_hit", 32'h00a1_b220, 1'b1, d, lat, r);
		check_word("write_hit", "latency", 32'd1, lat);
		access("write_hit_readback", 32'h00a1_b220, 1'b0, '0, lat, r);
		check_line("write_hit_readback", "data", d, r);
	endtask

	task automatic write_miss_then_read();
		l2_types_pkg::l2_line_t d;
		l2_types_pkg::l2_line_t r;
		int lat;
		d = random_line();
		access("write_miss", 32'h0033_4440, 1'b1, d, lat, r);
		access("write_miss_readback", 32'h0033_4440, 1'b0, '0, lat, r);
		check_line("write_miss_readback", "data", d, r);
	endtask

	task automatic replacement_order();
		l2_types_pkg::l2_tag_t tags [5];
		l2_types_pkg::l2_tag_t vt;
		l2_types_pkg::l2_line_t r;
		int lat;
		for (int i = 0; i < 5; i++)
			tags[i] = 24'h100000 + 24'(i);
		for (int i = 0; i < 4; i++)
			access("replace_fill", addr_of(tags[i], 3'd5), 1'b0, '0, lat, r);
		access("replace_touch", addr_of(tags[0], 3'd5), 1'b0, '0, lat, r);
		access("replace_touch", addr_of(tags[2], 3'd5), 1'b0, '0, lat, r);
		vt = m_tag[5][victim_of(m_lru[5])];
		access("replace_new", addr_of(tags[4], 3'd5), 1'b0, '0, lat, r);
		for (int i = 0; i < 5; i++) begin
			if (tags[i] != vt) begin
				access("replace_kept", addr_of(tags[i], 3'd5), 1'b0, '0, lat, r);
				check_word("replace_kept", "latency", 32'd1, lat);
			end
		end
		access("replace_evicted", addr_of(vt, 3'd5), 1'b0, '0, lat, r);
		checks++;
		if (lat <= 1) begin
			errors++;
			$display("replace_evicted: tag %0h should have been evicted but still hit", vt);
		end
	endtask

	task automatic dirty_writeback();
		l2_types_pkg::l2_tag_t tags [5];
		l2_types_pkg::l2_line_t d;
		l2_types_pkg::l2_line_t r;
		int lat;
		int start;
		for (int i = 0; i < 5; i++)
			tags[i] = 24'h200000 + 24'(i);
		d = random_line();
		access("wb_write", addr_of(tags[0], 3'd6), 1'b1, d, lat, r);
		for (int i = 1; i < 4; i++)
			access("wb_fill", addr_of(tags[i], 3'd6), 1'b0, '0, lat, r);
		start = log_addr.size();
		access("wb_evict", addr_of(tags[4], 3'd6), 1'b0, '0, lat, r);
		if (log_addr.size() < start + 2) begin
			checks++;
			errors++;
			$display("wb_evict: expected a write-back and a fill, saw %0d memory accesses",
				log_addr.size() - start);
		end else begin
			check_word("wb_evict", "first access is a write", 32'd1, 32'(log_wr[start]));
			check_word("wb_evict", "write-back address", addr_of(tags[0], 3'd6),
				log_addr[start]);
			check_line("wb_evict", "write-back data", d, log_data[start]);
			check_word("wb_evict", "fill address", addr_of(tags[4], 3'd6),
				log_addr[start+1]);
		end
	endtask

	initial begin
		void'($urandom(47));
		rst = 1'b1;
		mem_address = '0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_wdata = '0;
		for (int s = 0; s < sets; s++) begin
			m_lru[s] = '0;
			for (int w = 0; w < `L2_WAYS; w++) begin
				m_tag[s][w] = '0;
				m_valid[s][w] = 1'b0;
				m_dirty[s][w] = 1'b0;
				m_data[s][w] = '0;
			end
		end
		repeat (4) @(posedge clk);
		#2;
		rst = 1'b0;

		reset_outputs_low();
		read_miss_then_hit();
		write_hit_then_read();
		write_miss_then_read();
		replacement_order();
		dirty_writeback();

		errors += int'(l2_cache_i.l2_cache_properties_i.failures);
		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
			l2_cache_i.l2_cache_properties_i.failures);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule : l2_cache_tb

`default_nettype wire

//--- flist.f
+incdir+.
l2_types_pkg.sv
l2_ctrl_pkg.sv
l2_tag_lookup.sv
l2_cache_control.sv
l2_data_path.sv
l2_cache.sv
l2_cache_properties.sv
l2_cache_tb.sv

//--- run.sh
#!/bin/sh
set -e

verilator --binary --timing --assert --top-module l2_cache_tb -f flist.f -o l2_cache_sim

./obj_dir/l2_cache_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

if grep -q "Errors found" sim.log; then
	exit 1
fi
